// File: rtl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int cmd_width = 16;
  localparam int data_bits = 8;

  // command seen as register access fields.
  typedef struct packed {
    logic                 rw;   // 1 is write, 0 is read.
    logic [6:0]           addr;
    logic [data_bits-1:0] data;
  } cmd_fields_t;

  // the same word seen as the two bytes put on the line, hi first.
  typedef struct packed {
    logic [data_bits-1:0] hi;
    logic [data_bits-1:0] lo;
  } cmd_bytes_t;

  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_u;

  // result of a read command.
  typedef enum logic [1:0] {
    err_none,
    err_parity,
    err_stop,
    err_timeout   // no start bit within the reply window.
  } read_err_e;

endpackage

// File: rtl/uart_byte_if.sv
`timescale 1ns/10ps

interface uart_byte_if;

  logic                                tx_start;       // one cycle.
  logic [uart_cmd_pkg::data_bits-1:0]  tx_byte;
  logic                                tx_busy;
  logic                                rx_en;
  logic                                rx_done;        // one cycle.
  logic [uart_cmd_pkg::data_bits-1:0]  rx_byte;
  logic                                rx_parity_ok;
  logic                                rx_stop_ok;
  logic                                rx_start_seen;  // one cycle.

  modport seq (
    output tx_start, tx_byte, rx_en,
    input  tx_busy, rx_done, rx_byte, rx_parity_ok, rx_stop_ok, rx_start_seen
  );

  modport tx (
    input  tx_start, tx_byte,
    output tx_busy
  );

  modport rx (
    input  rx_en,
    output rx_done, rx_byte, rx_parity_ok, rx_stop_ok, rx_start_seen
  );

endinterface

// File: rtl/uart_tx_frame.sv
`timescale 1ns/10ps

module uart_tx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic    clk,
  input  logic    rst_n,
  uart_byte_if.tx bus,
  output logic    tx
);

  localparam int cnt_w      = $clog2(clks_per_bit + 1);
  localparam int frame_bits = uart_cmd_pkg::data_bits + 2;  // bits after the start bit.
  localparam int bit_w      = $clog2(frame_bits + 1);

  logic [cnt_w-1:0]      baud_cnt;
  logic [bit_w-1:0]      bit_cnt;
  logic [frame_bits-1:0] shreg;
  logic                  busy;
  logic                  bit_end;

  assign bit_end     = (baud_cnt == cnt_w'(clks_per_bit - 1));
  assign bus.tx_busy = busy;

  // stop, parity and data, shifted out from bit 0.
  always_ff @(posedge clk)
  begin
    if (bus.tx_start && !busy)
      shreg <= {1'b1, ~^bus.tx_byte, bus.tx_byte};
    else if (busy && bit_end)
      shreg <= {1'b1, shreg[frame_bits-1:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else if (!busy)
    begin
      if (bus.tx_start)
      begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
        tx       <= 1'b0;  // start bit.
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_cnt == bit_w'(frame_bits))
        busy <= 1'b0;      // stop bit done, line stays high.
      else
      begin
        tx      <= shreg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

endmodule

// File: rtl/uart_rx_frame.sv
`timescale 1ns/10ps

module uart_rx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    rx,
  uart_byte_if.rx bus
);

  localparam int cnt_w = $clog2(clks_per_bit + 1);
  localparam int bit_w = $clog2(uart_cmd_pkg::data_bits + 1);

  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_start  = 3'd1;
  localparam logic [2:0] st_data   = 3'd2;
  localparam logic [2:0] st_parity = 3'd3;
  localparam logic [2:0] st_stop   = 3'd4;

  logic [2:0]                         state;
  logic                               rx_meta;
  logic                               rx_sync;
  logic                               rx_prev;
  logic [cnt_w-1:0]                   baud_cnt;
  logic [bit_w-1:0]                   bit_cnt;
  logic [uart_cmd_pkg::data_bits-1:0] shreg;
  logic                               half_bit;
  logic                               full_bit;
  logic                               done_q;
  logic                               seen_q;
  logic                               parity_ok;
  logic                               stop_ok;

  assign half_bit = (baud_cnt == cnt_w'(clks_per_bit / 2 - 1));
  assign full_bit = (baud_cnt == cnt_w'(clks_per_bit - 1));

  assign bus.rx_done       = done_q;
  assign bus.rx_start_seen = seen_q;
  assign bus.rx_byte       = shreg;
  assign bus.rx_parity_ok  = parity_ok;
  assign bus.rx_stop_ok    = stop_ok;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;  // idle line is high.
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // data arrives LSB first.
  always_ff @(posedge clk)
  begin
    if (bus.rx_en && state == st_data && full_bit)
      shreg <= {rx_sync, shreg[uart_cmd_pkg::data_bits-1:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= st_idle;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      done_q    <= 1'b0;
      seen_q    <= 1'b0;
      parity_ok <= 1'b0;
      stop_ok   <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      seen_q <= 1'b0;
      if (!bus.rx_en)
        state <= st_idle;
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
        case (state)
          st_idle:
          begin
            baud_cnt <= '0;
            if (rx_prev && !rx_sync)
              state <= st_start;
          end
          st_start:
            if (half_bit)
            begin
              baud_cnt <= '0;  // from here on every full count lands mid-bit.
              bit_cnt  <= '0;
              seen_q   <= !rx_sync;
              state    <= rx_sync ? st_idle : st_data;
            end
          st_data:
            if (full_bit)
            begin
              baud_cnt <= '0;
              bit_cnt  <= bit_cnt + 1'b1;
              if (bit_cnt == bit_w'(uart_cmd_pkg::data_bits - 1))
                state <= st_parity;
            end
          st_parity:
            if (full_bit)
            begin
              baud_cnt  <= '0;
              parity_ok <= (rx_sync == ~^shreg);  // odd parity.
              state     <= st_stop;
            end
          st_stop:
            if (full_bit)
            begin
              stop_ok <= rx_sync;
              done_q  <= 1'b1;
              state   <= st_idle;
            end
          default:
            state <= st_idle;
        endcase
      end
    end
  end

endmodule

// File: rtl/uart_cmd_seq.sv
`timescale 1ns/10ps

module uart_cmd_seq #(
  parameter int gap_cycles    = 100,
  parameter int reply_timeout = 4000
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  uart_cmd_pkg::cmd_word_u            cmd_in,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  output logic [uart_cmd_pkg::data_bits-1:0] read_data,
  output logic                               read_rdy,
  output uart_cmd_pkg::read_err_e            read_err,
  uart_byte_if.seq                           bus
);

  localparam int wait_max = (gap_cycles > reply_timeout) ? gap_cycles : reply_timeout;
  localparam int cnt_w    = $clog2(wait_max + 1);

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_send_hi    = 3'd1;
  localparam logic [2:0] st_gap        = 3'd2;
  localparam logic [2:0] st_send_lo    = 3'd3;
  localparam logic [2:0] st_wait_reply = 3'd4;
  localparam logic [2:0] st_receive    = 3'd5;
  localparam logic [2:0] st_finish     = 3'd6;

  logic [2:0]              state;
  uart_cmd_pkg::cmd_word_u cmd_q;
  logic [cnt_w-1:0]        wait_cnt;
  logic                    busy_q;
  logic                    start_q;
  logic                    accept;
  logic                    frame_done;
  logic                    gap_end;
  logic                    give_up;

  assign cmd_rdy    = (state == st_idle);
  assign read_rdy   = (state == st_finish);
  assign accept     = cmd_rdy && cmd_vld;
  assign frame_done = busy_q && !bus.tx_busy;
  // tx_start is registered, so it fires one count early to land the gap exactly.
  assign gap_end    = (wait_cnt == cnt_w'(gap_cycles - 2));
  assign give_up    = (wait_cnt == cnt_w'(reply_timeout - 1)) && !bus.rx_start_seen;

  assign bus.tx_start = start_q;
  assign bus.tx_byte  = (state == st_send_lo) ? cmd_q.bytes.lo : cmd_q.bytes.hi;
  assign bus.rx_en    = (state == st_wait_reply) || (state == st_receive);

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (state == st_receive && bus.rx_done)
      read_data <= bus.rx_byte;
    else if (state == st_wait_reply && give_up)
      read_data <= '0;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      wait_cnt <= '0;
      busy_q   <= 1'b0;
      start_q  <= 1'b0;
      read_err <= uart_cmd_pkg::err_none;
    end
    else
    begin
      busy_q   <= bus.tx_busy;
      start_q  <= 1'b0;
      wait_cnt <= wait_cnt + 1'b1;
      case (state)
        st_idle:
          if (accept)
          begin
            start_q <= 1'b1;  // address byte goes out first.
            state   <= st_send_hi;
          end
        st_send_hi:
          if (frame_done)
          begin
            wait_cnt <= '0;
            state    <= cmd_q.fields.rw ? st_gap : st_wait_reply;
          end
        st_gap:
          if (gap_end)
          begin
            start_q <= 1'b1;
            state   <= st_send_lo;
          end
        st_send_lo:
          if (frame_done)
            state <= st_idle;
        st_wait_reply:
          if (bus.rx_start_seen)
            state <= st_receive;
          else if (give_up)
          begin
            read_err <= uart_cmd_pkg::err_timeout;
            state    <= st_finish;
          end
        st_receive:
          if (bus.rx_done)
          begin
            if (!bus.rx_parity_ok)
              read_err <= uart_cmd_pkg::err_parity;  // parity wins over stop.
            else if (!bus.rx_stop_ok)
              read_err <= uart_cmd_pkg::err_stop;
            else
              read_err <= uart_cmd_pkg::err_none;
            state <= st_finish;
          end
        st_finish:
          state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

// File: rtl/uart_cmd_master.sv
`timescale 1ns/10ps

module uart_cmd_master #(
  parameter int clks_per_bit  = 434,
  parameter int gap_cycles    = 100,
  parameter int reply_timeout = 4000
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0] cmd_in,
  input  logic                               cmd_vld,
  input  logic                               rx,
  output logic                               tx,
  output logic                               cmd_rdy,
  output logic [uart_cmd_pkg::data_bits-1:0] read_data,
  output logic                               read_rdy,
  output uart_cmd_pkg::read_err_e            read_err
);

  uart_byte_if byte_bus ();

  // command FSM drives both frame engines.
  uart_cmd_seq #(
    .gap_cycles    (gap_cycles),
    .reply_timeout (reply_timeout)
  ) seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .bus       (byte_bus.seq)
  );

  uart_tx_frame #(
    .clks_per_bit (clks_per_bit)
  ) tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (byte_bus.tx),
    .tx    (tx)
  );

  uart_rx_frame #(
    .clks_per_bit (clks_per_bit)
  ) rx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .bus   (byte_bus.rx)
  );

endmodule

// File: bench/uart_cmd_assertions.sv
`timescale 1ns/10ps

module uart_cmd_assertions (
  input logic clk,
  input logic rst_n,
  input logic tx_start,
  input logic tx_busy,
  input logic cmd_rdy,
  input logic read_rdy
);

  // no new frame while one is on the line.
  start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(tx_start && tx_busy))
    else $error("tx_start asserted while tx_busy is high");

  read_rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy wider than one cycle");

  // cmd_rdy only comes back right after a read result or the end of a frame.
  rdy_returns_at_end: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> ($past(read_rdy) || ($past(tx_busy, 2) && !$past(tx_busy))))
    else $error("cmd_rdy rose before the command finished");

endmodule

bind uart_cmd_seq uart_cmd_assertions asrt_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx_start (bus.tx_start),
  .tx_busy  (bus.tx_busy),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy)
);

// File: bench/uart_cmd_checker.sv
`timescale 1ns/10ps

module uart_cmd_checker #(
  parameter int clks_per_bit = 8
) (
  input logic                    clk,
  input logic                    tx,
  input logic                    cmd_rdy,
  input logic [7:0]              read_data,
  input logic                    read_rdy,
  input uart_cmd_pkg::read_err_e read_err
);

  int tests_run    = 0;
  int tests_failed = 0;
  int hi_frames    = 0;  // the reply model follows this.
  int rdy_pulses   = 0;
  bit test_ok;

  always @(negedge clk)
  begin
    if (read_rdy)
      rdy_pulses++;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
      test_ok = 0;
    end
  endtask

  task automatic decode_frame(input logic [7:0] exp_byte, input string name);
    int waited;
    logic [7:0] got;
    logic par;
    logic stp;
    waited = 0;
    while (tx !== 1'b0 && waited < 2000)
    begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0)
    begin
      $display("%0t: no frame for %s ever started on tx", $time, name);
      test_ok = 0;
      return;
    end
    repeat (clks_per_bit / 2 - 1) @(negedge clk);  // middle of the start bit.
    if (tx !== 1'b0)
    begin
      $display("%0t: start bit of %s did not last to mid-bit", $time, name);
      test_ok = 0;
      return;
    end
    for (int i = 0; i < 8; i++)
    begin
      repeat (clks_per_bit) @(negedge clk);
      got[i] = tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    par = tx;
    repeat (clks_per_bit) @(negedge clk);
    stp = tx;
    compare(name, exp_byte, got);
    // parity bit makes the count of ones odd.
    compare("tx parity", ($countones(exp_byte) % 2) == 0, par);
    compare("tx stop", 1, stp);
  endtask

  task automatic check_idle();
    test_ok = 1;
    compare("tx", 1, tx);
    compare("cmd_rdy", 1, cmd_rdy);
    compare("read_rdy", 0, read_rdy);
    compare("read_err", 0, read_err);
    tests_run++;
    if (!test_ok)
      tests_failed++;
    $display("test 0 reset state: %s", test_ok ? "ok" : "failed");
  endtask

  task automatic check_test(input int n, input logic [15:0] cmd,
                            input logic [7:0] exp_data, input logic [1:0] exp_err);
    uart_cmd_pkg::cmd_word_u w;
    int pulses0;
    int waited;
    bit tx_low;
    w       = cmd;
    test_ok = 1;
    tx_low  = 0;
    pulses0 = rdy_pulses;
    decode_frame({w.fields.rw, w.fields.addr}, "tx hi byte");
    hi_frames++;
    waited = 0;
    if (w.fields.rw)
    begin
      decode_frame(w.fields.data, "tx lo byte");
      while (cmd_rdy !== 1'b1 && waited < 200)
      begin
        @(negedge clk);
        waited++;
        if (tx !== 1'b1)
          tx_low = 1;
      end
      if (cmd_rdy !== 1'b1)
      begin
        $display("%0t: cmd_rdy never came back after a write", $time);
        test_ok = 0;
      end
      compare("read_rdy pulses", pulses0, rdy_pulses);
    end
    else
    begin
      while (read_rdy !== 1'b1 && waited < 2000)
      begin
        @(negedge clk);
        waited++;
        if (tx !== 1'b1)
          tx_low = 1;
      end
      if (read_rdy !== 1'b1)
      begin
        $display("%0t: read_rdy never pulsed for a read", $time);
        test_ok = 0;
      end
      else
      begin
        compare("read_data", exp_data, read_data);
        compare("read_err", exp_err, read_err);
        @(negedge clk);
        compare("cmd_rdy", 1, cmd_rdy);
      end
    end
    if (tx_low)
    begin
      $display("%0t: tx left idle after the last expected frame", $time);
      test_ok = 0;
    end
    tests_run++;
    if (!test_ok)
      tests_failed++;
    $display("test %0d %s %04h: %s", n, w.fields.rw ? "write" : "read", cmd,
             test_ok ? "ok" : "failed");
  endtask

endmodule

// File: bench/tb_uart_cmd_master.sv
`timescale 1ns/10ps

module tb_uart_cmd_master;

  localparam int clks_per_bit = 8;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        tx;
  logic        cmd_rdy;
  logic [7:0]  read_data;
  logic        read_rdy;
  uart_cmd_pkg::read_err_e read_err;

  int unsigned lcg_state = 18;
  int          bench_errors = 0;

  uart_cmd_master #(
    .clks_per_bit  (clks_per_bit),
    .gap_cycles    (20),
    .reply_timeout (400)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_cmd_checker #(
    .clks_per_bit (clks_per_bit)
  ) checker_i (
    .clk       (clk),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  always #20 clk = ~clk;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic send_bit(input logic b);
    rx = b;
    repeat (clks_per_bit) @(negedge clk);
  endtask

  // plays the remote device, mode 1 flips parity and mode 2 pulls stop low.
  task automatic reply_device(input logic [7:0] reply, input int mode, input bit is_read);
    int h0;
    int waited;
    h0     = checker_i.hi_frames;
    waited = 0;
    while (checker_i.hi_frames == h0 && waited < 3000)
    begin
      @(negedge clk);
      waited++;
    end
    cmd_vld = 1'b0;
    if (checker_i.hi_frames == h0)
    begin
      $display("%0t: address frame was never decoded", $time);
      bench_errors++;
    end
    else if (is_read && mode != 3)
    begin
      repeat (lcg_next() % 60 + 10) @(negedge clk);
      send_bit(1'b0);
      for (int i = 0; i < 8; i++)
        send_bit(reply[i]);
      send_bit((~^reply) ^ (mode == 1));
      send_bit(mode != 2);
      rx = 1'b1;
    end
  endtask

  initial
  begin
    int fd;
    int n;
    string line;
    logic [15:0] cmd;
    logic [7:0]  reply;
    logic [7:0]  exp_data;
    int mode;
    int exp_err;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    checker_i.check_idle();
    n  = 0;
    fd = $fopen("bench/uart_cmd_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the pattern file");
      bench_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#")
          if ($sscanf(line, "%h %h %d %h %d", cmd, reply, mode, exp_data, exp_err) == 5)
          begin
            n++;
            @(negedge clk);
            cmd_in  = cmd;
            cmd_vld = 1'b1;  // held high through the first frame.
            fork
              checker_i.check_test(n, cmd, exp_data, exp_err[1:0]);
              reply_device(reply, mode, !cmd[15]);
            join
          end
      end
      $fclose(fd);
    end
    $display("tests run %0d, failed %0d, bench errors %0d",
             checker_i.tests_run, checker_i.tests_failed, bench_errors);
    if (checker_i.tests_failed == 0 && bench_errors == 0 && n > 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: bench/uart_cmd_patterns.txt
# cmd(hex) reply(hex) mode exp_data(hex) exp_err
# mode 0 clean, 1 bad parity, 2 bad stop, 3 no reply; err 0 none, 1 parity, 2 stop, 3 timeout
925a 00 0 00 0
3400 a5 0 a5 0
ff01 00 0 00 0
1100 3c 1 3c 1
2200 c3 2 c3 2
4500 00 3 00 3
0a00 7e 0 7e 0
8000 00 0 00 0
7f00 01 0 01 0

// File: all.f
rtl/uart_cmd_pkg.sv
rtl/uart_byte_if.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_seq.sv
rtl/uart_cmd_master.sv
bench/uart_cmd_assertions.sv
bench/uart_cmd_checker.sv
bench/tb_uart_cmd_master.sv

// File: Bender.yml
package:
  name: uart_cmd_master

sources:
  - rtl/uart_cmd_pkg.sv
  - rtl/uart_byte_if.sv
  - rtl/uart_tx_frame.sv
  - rtl/uart_rx_frame.sv
  - rtl/uart_cmd_seq.sv
  - rtl/uart_cmd_master.sv
  - target: test
    files:
      - bench/uart_cmd_assertions.sv
      - bench/uart_cmd_checker.sv
      - bench/tb_uart_cmd_master.sv
